// File: all.f
+incdir+source
source/cpuPkg.sv
source/InstructionMemory.sv
source/RegisterFile.sv
source/Control.sv
source/Alu.sv
source/IoBus.sv
source/GcdCpu.sv
tests/GcdCpuChecker.sv
tests/GcdCpuTb.sv

// File: Makefile
obj_dir/VGcdCpuTb: all.f $(wildcard source/*.sv source/*.svh tests/*.sv)
	verilator --binary --timing --top-module GcdCpuTb -f all.f

run: obj_dir/VGcdCpuTb
	./obj_dir/VGcdCpuTb > sim.log
	cat sim.log
	! grep -q "Checks failed" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: run clean

// File: tests/GcdCpuTb.sv
`default_nettype none
`timescale 1ns/1ns
`include "gcdCpu_consts.svh"

module GcdCpuTb;

	localparam int timeoutCycles = 20000;
	localparam int randomPairs = 200;
	localparam int expectedChecks = 8 + randomPairs; // fixed, zero rule, random, overwrite

	logic                  clk;
	logic                  rstN;
	logic                  start;
	logic [`dataWidth-1:0] operandA, operandB;
	logic [`dataWidth-1:0] result;
	logic                  resultValid;
	logic [8*24-1:0]       testName;
	logic [`dataWidth-1:0] randA, randB;
	int                    errorCount, checkCount, timeoutCount;
	int                    idx;
	integer                seed;

	always #20 clk = ~clk; // 40 ns period

	GcdCpu dut0 (
		.clk         (clk),
		.rstN        (rstN),
		.start       (start),
		.operandA    (operandA),
		.operandB    (operandB),
		.result      (result),
		.resultValid (resultValid)
	);

	GcdCpuChecker checker0 (
		.clk         (clk),
		.rstN        (rstN),
		.start       (start),
		.operandA    (operandA),
		.operandB    (operandB),
		.result      (result),
		.resultValid (resultValid),
		.testName    (testName),
		.errorCount  (errorCount),
		.checkCount  (checkCount)
	);

	// one cycle start with a new pair, 2 ns after the edge
	task automatic pulseStart(input logic [`dataWidth-1:0] a, input logic [`dataWidth-1:0] b);
		@(posedge clk);
		#2;
		operandA = a;
		operandB = b;
		start = 1'b1;
		@(posedge clk);
		#2;
		start = 1'b0;
	endtask

	// bounded wait for the result strobe
	task automatic waitResult(input logic [8*24-1:0] name);
		int cycles;
		cycles = 0;
		while (resultValid !== 1'b1 && cycles < timeoutCycles) begin
			@(negedge clk);
			cycles++;
		end
		if (resultValid !== 1'b1) begin
			$display("timed out waiting for resultValid in %0s", name);
			timeoutCount++;
		end
	endtask

	task automatic runPair(input logic [8*24-1:0] name, input logic [`dataWidth-1:0] a,
			input logic [`dataWidth-1:0] b);
		pulseStart(a, b);
		testName = name; // label moves off the falling edge the checker samples on
		waitResult(name);
	endtask

	initial begin
		clk = 1'b0;
		rstN = 1'b0;
		start = 1'b0;
		operandA = '0;
		operandB = '0;
		testName = "reset";
		timeoutCount = 0;
		seed = 32'h2db9_747a;
		repeat (16) @(posedge clk);
		#2;
		rstN = 1'b1;
		testName = "idle";
		repeat (20) @(posedge clk); // result must stay zero here

		runPair("fixed", 48, 18);
		runPair("fixed", 17, 5);
		runPair("fixed", 100, 100);
		runPair("fixed", 1, 999);

		runPair("zero rule", 0, 35);
		runPair("zero rule", 42, 0);
		runPair("zero rule", 0, 0);

		for (idx = 0; idx < randomPairs; idx++) begin
			randA = $random(seed) & 32'hfff; // 12 bits keeps the loop short
			randB = $random(seed) & 32'hfff;
			runPair("random", randA, randB);
		end

		// two adjacent starts, the second pair must win
		@(posedge clk);
		#2;
		testName = "overwrite";
		operandA = 84;
		operandB = 36;
		start = 1'b1;
		@(posedge clk);
		#2;
		operandA = 91;
		operandB = 35;
		@(posedge clk);
		#2;
		start = 1'b0;
		waitResult("overwrite");
		repeat (50) @(posedge clk); // room for a stray extra pulse

		$display("checks %0d of %0d, errors %0d, timeouts %0d", checkCount, expectedChecks,
			errorCount, timeoutCount);
		if (errorCount == 0 && timeoutCount == 0 && checkCount == expectedChecks) begin
			$display("All checks passed");
		end else begin
			$display("Checks failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: tests/GcdCpuChecker.sv
`default_nettype none
`timescale 1ns/1ns
`include "gcdCpu_consts.svh"

module GcdCpuChecker (
	input  wire                   clk,
	input  wire                   rstN,
	input  wire                   start,
	input  wire  [`dataWidth-1:0] operandA,
	input  wire  [`dataWidth-1:0] operandB,
	input  wire  [`dataWidth-1:0] result,
	input  wire                   resultValid,
	input  wire  [8*24-1:0]       testName, // label of the running test
	output int                    errorCount,
	output int                    checkCount // results compared
);

	logic [`dataWidth-1:0] expA, expB; // latest pair seen on start
	logic [`dataWidth-1:0] expected;
	logic                  awaiting;  // a start has no result yet
	logic                  startSeen;
	logic                  lastValid; // resultValid at the previous sample

	// euclid by remainder, gcd(x, 0) = x gives both zero rules
	function automatic logic [`dataWidth-1:0] refGcd(input logic [`dataWidth-1:0] x,
			input logic [`dataWidth-1:0] y);
		logic [`dataWidth-1:0] t;
		while (y != '0) begin
			t = x % y;
			x = y;
			y = t;
		end
		return x;
	endfunction

	initial begin
		errorCount = 0;
		checkCount = 0;
		expA = '0;
		expB = '0;
		expected = '0;
		awaiting = 1'b0;
		startSeen = 1'b0;
		lastValid = 1'b0;
	end

	// outputs settle after the rising edge, sample on the falling one
	always @(negedge clk) begin
		if (rstN) begin
			if (resultValid) begin
				if (lastValid) begin
					$display("Error: resultValid stayed high for more than one cycle in %0s",
						testName);
					errorCount++;
				end else if (!awaiting) begin
					$display("Error: resultValid came without a preceding start in %0s",
						testName);
					errorCount++;
				end else begin
					expected = refGcd(expA, expB);
					checkCount++;
					if (result !== expected) begin
						$display("Error: %0s expected %0d actual %0d", testName, expected,
							result);
						errorCount++;
					end
					awaiting = 1'b0;
				end
			end else if (!startSeen && result !== '0) begin
				$display("Error: result left zero before the first start, actual %0d", result);
				errorCount++;
			end
			if (start) begin // a later start replaces the pair
				expA = operandA;
				expB = operandB;
				awaiting = 1'b1;
				startSeen = 1'b1;
			end
			lastValid = resultValid;
		end
	end

endmodule

`default_nettype wire

// File: source/GcdCpu.sv
`default_nettype none
`timescale 1ns/1ns
`include "gcdCpu_consts.svh"

module GcdCpu import cpuPkg::*; (
	input  wire                   clk,
	input  wire                   rstN,
	input  wire                   start,
	input  wire  [`dataWidth-1:0] operandA,
	input  wire  [`dataWidth-1:0] operandB,
	output logic [`dataWidth-1:0] result,
	output logic                  resultValid
);

	logic [`dataWidth-1:0] pc, pcPlus4, nextPc;
	logic [`dataWidth-1:0] instruction;
	logic [`dataWidth-1:0] readDataA, readDataB;
	logic [`dataWidth-1:0] immExt, aluB, aluResult, memData, writeBack;
	logic [`dataWidth-1:0] branchTarget, jumpTarget;
	logic [15:0]           imm;
	logic [4:0]            writeAddr;
	logic                  zero, branchTaken;
	instrFieldsT           fields;
	controlT               control;

	assign fields = instrFieldsT'(instruction);
	assign imm = {fields.rd, fields.shamt, fields.funct}; // low half of the word
	assign immExt = control.zeroExtend ? {16'b0, imm} : {{16{imm[15]}}, imm};
	assign aluB = control.aluSrcImm ? immExt : readDataB;

	// next pc
	assign pcPlus4 = pc + 32'd4;
	assign branchTarget = pcPlus4 + {immExt[`dataWidth-3:0], 2'b00};
	assign jumpTarget = {pcPlus4[31:28], fields.rs, fields.rt, imm, 2'b00};
	assign branchTaken = (control.branchEq & zero) | (control.branchNe & ~zero);

	always_comb begin
		if (control.jumpReg) nextPc = readDataA; // jr
		else if (control.jump) nextPc = jumpTarget;
		else if (branchTaken) nextPc = branchTarget;
		else nextPc = pcPlus4;
	end

	always_ff @(posedge clk) begin
		if (!rstN) pc <= '0;
		else pc <= nextPc;
	end

	// write back
	assign writeAddr = control.jumpLink ? 5'd31 : (control.regDstRd ? fields.rd : fields.rt);
	assign writeBack = control.jumpLink ? pcPlus4 : (control.memRead ? memData : aluResult);

	InstructionMemory instructionMemory0 (
		.address     (pc),
		.instruction (instruction)
	);

	Control control0 (
		.fields  (fields),
		.control (control)
	);

	RegisterFile registerFile0 (
		.clk         (clk),
		.rstN        (rstN),
		.readAddrA   (fields.rs),
		.readAddrB   (fields.rt),
		.writeEnable (control.regWrite),
		.writeAddr   (writeAddr),
		.writeData   (writeBack),
		.readDataA   (readDataA),
		.readDataB   (readDataB)
	);

	Alu alu0 (
		.a      (readDataA),
		.b      (aluB),
		.shamt  (fields.shamt),
		.aluOp  (control.aluOp),
		.result (aluResult),
		.zero   (zero)
	);

	IoBus ioBus0 (
		.clk         (clk),
		.rstN        (rstN),
		.address     (aluResult), // base + offset
		.writeData   (readDataB),
		.memRead     (control.memRead),
		.memWrite    (control.memWrite),
		.start       (start),
		.operandA    (operandA),
		.operandB    (operandB),
		.readData    (memData),
		.result      (result),
		.resultValid (resultValid)
	);

endmodule

`default_nettype wire

// File: source/IoBus.sv
`default_nettype none
`timescale 1ns/1ns
`include "gcdCpu_consts.svh"

module IoBus (
	input  wire                   clk,
	input  wire                   rstN,
	input  wire  [`dataWidth-1:0] address,
	input  wire  [`dataWidth-1:0] writeData,
	input  wire                   memRead,
	input  wire                   memWrite,
	input  wire                   start,
	input  wire  [`dataWidth-1:0] operandA,
	input  wire  [`dataWidth-1:0] operandB,
	output logic [`dataWidth-1:0] readData,
	output logic [`dataWidth-1:0] result,
	output logic                  resultValid
);

	localparam int ramAddrBits = $clog2(`ramWords);
	localparam logic [`dataWidth-1:0] addrOperandA = `ioBase + `ioOperandA;
	localparam logic [`dataWidth-1:0] addrOperandB = `ioBase + `ioOperandB;
	localparam logic [`dataWidth-1:0] addrResult = `ioBase + `ioResult;
	localparam logic [`dataWidth-1:0] addrPending = `ioBase + `ioPending;

	logic [`dataWidth-1:0] ram [`ramWords];
	logic [`dataWidth-1:0] capA, capB; // operands held for the program
	logic                  pending;
	logic                  ioSel;
	logic [ramAddrBits-1:0] ramIndex;

	assign ioSel = address >= `ioBase; // everything above the base is I/O
	assign ramIndex = address[ramAddrBits+1:2];

	always_ff @(posedge clk) begin
		if (memWrite && !ioSel) begin
			ram[ramIndex] <= writeData;
		end
		if (start) begin
			capA <= operandA; // a second start overwrites the pair
			capB <= operandB;
		end
	end

	always_ff @(posedge clk) begin
		if (!rstN) begin
			pending <= 1'b0;
			result <= '0;
			resultValid <= 1'b0;
		end else begin
			resultValid <= 1'b0; // one cycle pulse
			if (start) begin
				pending <= 1'b1;
			end else if (memRead && address == addrOperandB) begin
				pending <= 1'b0; // reading b consumes the pair
			end
			if (memWrite && address == addrResult) begin
				result <= writeData;
				resultValid <= 1'b1;
			end
		end
	end

	always_comb begin
		readData = '0;
		if (memRead) begin
			if (!ioSel) begin
				readData = ram[ramIndex];
			end else begin
				case (address)
					addrOperandA: readData = capA;
					addrOperandB: readData = capB;
					addrResult:   readData = result;
					addrPending:  readData = {{(`dataWidth-1){1'b0}}, pending};
					default:      readData = '0; // unmapped I/O reads zero
				endcase
			end
		end
	end

endmodule

`default_nettype wire

// File: source/Alu.sv
`default_nettype none
`timescale 1ns/1ns
`include "gcdCpu_consts.svh"

module Alu import cpuPkg::*; (
	input  wire  [`dataWidth-1:0] a,
	input  wire  [`dataWidth-1:0] b,
	input  wire  [4:0]            shamt,
	input  aluOpT                 aluOp,
	output logic [`dataWidth-1:0] result,
	output logic                  zero
);

	logic lessThan;

	assign lessThan = $signed(a) < $signed(b); // slt is signed

	always_comb begin
		case (aluOp)
			opAdd: result = a + b;
			opSub: result = a - b;
			opAnd: result = a & b;
			opOr:  result = a | b;
			opNor: result = ~(a | b);
			opSlt: result = {{(`dataWidth-1){1'b0}}, lessThan};
			opSll: result = b << shamt;
			opSrl: result = b >> shamt; // logical, no sign fill
			opLui: result = b << 16; // immediate into the upper half
			default: result = '0;
		endcase
	end

	assign zero = (result == '0); // beq/bne look at this after a subtract

endmodule

`default_nettype wire

// File: source/Control.sv
`default_nettype none
`timescale 1ns/1ns

module Control import cpuPkg::*; (
	input  instrFieldsT fields,
	output controlT     control
);

	always_comb begin
		control = '0; // unknown words do nothing
		control.aluOp = opAdd;
		case (fields.opcode)
			instR: begin
				control.regWrite = 1'b1;
				control.regDstRd = 1'b1;
				case (fields.funct)
					fnAdd: control.aluOp = opAdd;
					fnSub: control.aluOp = opSub;
					fnAnd: control.aluOp = opAnd;
					fnOr:  control.aluOp = opOr;
					fnNor: control.aluOp = opNor;
					fnSlt: control.aluOp = opSlt;
					fnSll: control.aluOp = opSll; // shifts take rt and shamt
					fnSrl: control.aluOp = opSrl;
					fnJr: begin
						control.regWrite = 1'b0;
						control.jumpReg = 1'b1;
					end
					default: control.regWrite = 1'b0; // unsupported funct
				endcase
			end
			instAddi: begin
				control.regWrite = 1'b1;
				control.aluSrcImm = 1'b1;
			end
			instAndi: begin
				control.regWrite = 1'b1;
				control.aluSrcImm = 1'b1;
				control.zeroExtend = 1'b1; // logical immediate
				control.aluOp = opAnd;
			end
			instLui: begin
				control.regWrite = 1'b1;
				control.aluSrcImm = 1'b1;
				control.aluOp = opLui;
			end
			instLw: begin
				control.regWrite = 1'b1;
				control.aluSrcImm = 1'b1; // base + offset
				control.memRead = 1'b1;
			end
			instSw: begin
				control.aluSrcImm = 1'b1;
				control.memWrite = 1'b1;
			end
			instBeq: begin
				control.branchEq = 1'b1;
				control.aluOp = opSub; // zero flag compares rs, rt
			end
			instBne: begin
				control.branchNe = 1'b1;
				control.aluOp = opSub;
			end
			instJ: control.jump = 1'b1;
			instJal: begin
				control.jump = 1'b1;
				control.jumpLink = 1'b1;
				control.regWrite = 1'b1; // r31 gets pc+4
			end
			default: ;
		endcase
	end

endmodule

`default_nettype wire

// File: source/RegisterFile.sv
`default_nettype none
`timescale 1ns/1ns
`include "gcdCpu_consts.svh"

module RegisterFile #(
	parameter int addrBits = $clog2(`regCount)
) (
	input  wire                   clk,
	input  wire                   rstN,
	input  wire  [addrBits-1:0]   readAddrA,
	input  wire  [addrBits-1:0]   readAddrB,
	input  wire                   writeEnable,
	input  wire  [addrBits-1:0]   writeAddr,
	input  wire  [`dataWidth-1:0] writeData,
	output logic [`dataWidth-1:0] readDataA,
	output logic [`dataWidth-1:0] readDataB
);

	logic [`dataWidth-1:0] regs [`regCount]; // contents survive reset

	// no writes land while reset is held
	always_ff @(posedge clk) begin
		if (rstN && writeEnable && writeAddr != '0) begin
			regs[writeAddr] <= writeData;
		end
	end

	// asynchronous reads, r0 forced to zero
	always_comb begin
		readDataA = (readAddrA == '0) ? '0 : regs[readAddrA];
		readDataB = (readAddrB == '0) ? '0 : regs[readAddrB];
	end

endmodule

`default_nettype wire

// File: source/InstructionMemory.sv
`default_nettype none
`timescale 1ns/1ns
`include "gcdCpu_consts.svh"

// register use: r13 io base, r16/r17 the two operands, r8/r9 scratch, r31 link
module InstructionMemory import cpuPkg::*; (
	input  wire  [`dataWidth-1:0] address,
	output logic [`dataWidth-1:0] instruction
);

	always_comb begin
		case (address[7:2]) // word index
			// reset vector
			6'd0:  instruction = {instJ, 26'd16}; // j main

			// one subtract step, called by jal
			6'd8:  instruction = {instR, 5'd16, 5'd17, 5'd16, 5'd0, fnSub}; // sub r16, r16, r17
			6'd9:  instruction = {instR, 5'd31, 5'd0, 5'd0, 5'd0, fnJr}; // jr r31

			// main
			6'd16: instruction = {instLui, 5'd0, 5'd13, 16'(`ioBase >> 16)}; // lui r13, io base

			// poll until an operand pair is waiting
			6'd17: instruction = {instLw, 5'd13, 5'd8, 16'(`ioPending)}; // lw r8, pending
			6'd18: instruction = {instAndi, 5'd8, 5'd8, 16'd1}; // keep bit 0
			6'd19: instruction = {instBeq, 5'd8, 5'd0, 16'hfffd}; // back to 17
			6'd20: instruction = {instLw, 5'd13, 5'd16, 16'(`ioOperandA)}; // r16 = a
			6'd21: instruction = {instLw, 5'd13, 5'd17, 16'(`ioOperandB)}; // r17 = b, clears pending

			// zero rule
			6'd22: instruction = {instBeq, 5'd16, 5'd0, 16'd11}; // a == 0, to 34
			6'd23: instruction = {instBeq, 5'd17, 5'd0, 16'd8}; // b == 0, result is a

			// loop, keep the larger value in r16
			6'd24: instruction = {instR, 5'd16, 5'd17, 5'd9, 5'd0, fnSlt}; // r9 = r16 < r17
			6'd25: instruction = {instBeq, 5'd9, 5'd0, 16'd3}; // already ordered, to 29
			6'd26: instruction = {instR, 5'd16, 5'd0, 5'd8, 5'd0, fnAdd}; // swap through r8
			6'd27: instruction = {instR, 5'd17, 5'd0, 5'd16, 5'd0, fnAdd};
			6'd28: instruction = {instR, 5'd8, 5'd0, 5'd17, 5'd0, fnAdd};
			6'd29: instruction = {instJal, 26'd8}; // r16 -= r17
			6'd30: instruction = {instBne, 5'd16, 5'd0, 16'hfff9}; // nonzero difference, to 24
			6'd31: instruction = {instR, 5'd17, 5'd0, 5'd16, 5'd0, fnAdd}; // equal, gcd is r17

			// hand the result to the host
			6'd32: instruction = {instSw, 5'd13, 5'd16, 16'(`ioResult)}; // sw r16, result
			6'd33: instruction = {instJ, 26'd17}; // next pair

			// a was zero, gcd is b (zero when both are)
			6'd34: instruction = {instR, 5'd17, 5'd0, 5'd16, 5'd0, fnAdd};
			6'd35: instruction = {instJ, 26'd32};

			default: instruction = '0; // sll r0, r0, 0
		endcase
	end

endmodule

`default_nettype wire

// File: source/cpuPkg.sv
`default_nettype none

package cpuPkg;

	// primary opcode field, bits 31:26
	typedef enum logic [5:0] {
		instR    = 6'h00, // register format, operation in funct
		instJ    = 6'h02,
		instJal  = 6'h03,
		instBeq  = 6'h04,
		instBne  = 6'h05,
		instAddi = 6'h08,
		instAndi = 6'h0c,
		instLui  = 6'h0f,
		instLw   = 6'h23,
		instSw   = 6'h2b
	} opcodeT;

	// funct field of register-format words
	typedef enum logic [5:0] {
		fnSll = 6'h00,
		fnSrl = 6'h02,
		fnJr  = 6'h08,
		fnAdd = 6'h20,
		fnSub = 6'h22,
		fnAnd = 6'h24,
		fnOr  = 6'h25,
		fnNor = 6'h27,
		fnSlt = 6'h2a
	} functT;

	typedef enum logic [3:0] {
		opAdd, opSub, opAnd, opOr, opNor, opSlt, opSll, opSrl, opLui
	} aluOpT;

	typedef struct packed {
		logic  regWrite;  // write back to the register file
		logic  regDstRd;  // destination is rd, else rt
		logic  aluSrcImm; // alu b from the immediate
		logic  zeroExtend; // immediate is zero extended
		logic  memRead;
		logic  memWrite;
		logic  branchEq;
		logic  branchNe;
		logic  jump;      // 26-bit jump target
		logic  jumpLink;  // save pc+4 in r31
		logic  jumpReg;   // next pc from rs
		aluOpT aluOp;
	} controlT;

	// same slicing for every format, immediate is {rd, shamt, funct}
	typedef struct packed {
		opcodeT     opcode;
		logic [4:0] rs;
		logic [4:0] rt;
		logic [4:0] rd;
		logic [4:0] shamt;
		functT      funct;
	} instrFieldsT;

endpackage

`default_nettype wire

// File: source/gcdCpu_consts.svh
`ifndef gcdCpuConstsSvh
`define gcdCpuConstsSvh

// word, register and address width
`define dataWidth 32

// architectural registers, r0 hard wired to zero
`define regCount 32

// data RAM depth in words
`define ramWords 64

// start of the memory mapped I/O region
`define ioBase 32'h4000_0000

// byte offsets inside the I/O region
`define ioOperandA 0
`define ioOperandB 4
`define ioResult 8
`define ioPending 12

`endif
